/* verilog/telemetry_pkg.sv */
package telemetry_pkg;

    typedef logic [7:0] uart_byte_t;

    // one snapshot of the game as seen by the engine.
    typedef struct packed {
        logic [11:0] char_x;
        logic [11:0] char_y;
        logic [3:0]  char_hp;
        logic [3:0]  char_aggro;
        logic [11:0] boss_x;
        logic [11:0] boss_y;
        logic [6:0]  boss_hp;
    } game_state_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        LOAD = 2'b01,
        SEND = 2'b10
    } encoder_state_t;

    // bytes per line, including the trailing CR LF.
    localparam int FRAME_LEN   = 41;
    localparam int FRAME_IDX_W = 6;

    // Pacer period, short so that simulation stays fast.
    localparam int FRAME_INTERVAL = 4096;
    localparam int PACER_CNT_W    = 12;

    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_CNT_W   = 3;
    localparam int UART_BITS    = 10; // start, eight data bits and stop.
    localparam int BIT_CNT_W    = 4;

    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_ADDR_W = 4;

    localparam uart_byte_t ASCII_CR = 8'h0D;
    localparam uart_byte_t ASCII_LF = 8'h0A;

    // hex digits map 0..9 to '0'..'9' and 10..15 to 'A'..'F'.
    localparam uart_byte_t ASCII_ZERO    = 8'h30;
    localparam uart_byte_t ASCII_A_MINUS = 8'h37;

endpackage

/* verilog/state_change_detector.sv */
`timescale 1ns/1ps

module state_change_detector (
    input  logic                       clk,
    input  logic                       rst,
    input  telemetry_pkg::game_state_t state,
    input  logic                       frame_start,
    output logic                       changed
);

    telemetry_pkg::game_state_t last_sent;

    // the copy is taken when a frame starts, so a change held back by the
    // pacer keeps the flag up until a line actually carries it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_sent <= '0;
        end else if (frame_start) begin
            last_sent <= state;
        end
    end

    logic diff_char;
    logic diff_boss;

    always_comb begin
        diff_char = (state.char_x != last_sent.char_x)
                 || (state.char_y != last_sent.char_y)
                 || (state.char_hp != last_sent.char_hp)
                 || (state.char_aggro != last_sent.char_aggro);
        diff_boss = (state.boss_x != last_sent.boss_x)
                 || (state.boss_y != last_sent.boss_y)
                 || (state.boss_hp != last_sent.boss_hp);
    end

    assign changed = diff_char || diff_boss;

endmodule

/* verilog/frame_pacer.sv */
`timescale 1ns/1ps

module frame_pacer (
    input  logic clk,
    input  logic rst,
    input  logic frame_done,
    output logic credit
);

    logic [telemetry_pkg::PACER_CNT_W-1:0] count;
    logic                                  wrap;

    assign wrap = (count == telemetry_pkg::PACER_CNT_W'(telemetry_pkg::FRAME_INTERVAL - 1));

    // free running, the frames do not restart the interval.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // one credit per interval; a finished frame spends it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit <= 1'b1; // first frame may go out right after reset.
        end else if (wrap) begin
            credit <= 1'b1; // a new interval wins over a frame ending now.
        end else if (frame_done) begin
            credit <= 1'b0;
        end
    end

endmodule

/* verilog/telemetry_encoder.sv */
`timescale 1ns/1ps

module telemetry_encoder (
    input  logic                       clk,
    input  logic                       rst,
    input  telemetry_pkg::game_state_t state,
    input  logic                       changed,
    input  logic                       credit,
    input  logic                       full,
    output logic                       frame_start,
    output logic                       frame_done,
    output logic                       wr_en,
    output telemetry_pkg::uart_byte_t  wr_data
);

    telemetry_pkg::encoder_state_t         fsm;
    telemetry_pkg::encoder_state_t         fsm_next;
    telemetry_pkg::game_state_t            snap;
    logic [telemetry_pkg::FRAME_IDX_W-1:0] idx;
    logic                                  last_byte;

    function automatic telemetry_pkg::uart_byte_t to_hex(input logic [3:0] nib);
        telemetry_pkg::uart_byte_t base;
        if (nib < 4'd10) begin
            base = telemetry_pkg::ASCII_ZERO;
        end else begin
            base = telemetry_pkg::ASCII_A_MINUS;
        end
        return base + telemetry_pkg::uart_byte_t'(nib);
    endfunction

    assign frame_start = (fsm == telemetry_pkg::IDLE) && changed && credit;
    assign wr_en       = (fsm == telemetry_pkg::SEND) && !full;
    assign last_byte   = (idx == telemetry_pkg::FRAME_IDX_W'(telemetry_pkg::FRAME_LEN - 1));
    assign frame_done  = wr_en && last_byte;

    always_comb begin
        fsm_next = fsm;
        unique case (fsm)
            telemetry_pkg::IDLE: begin
                if (frame_start) begin
                    fsm_next = telemetry_pkg::LOAD;
                end
            end
            telemetry_pkg::LOAD: begin
                fsm_next = telemetry_pkg::SEND;
            end
            telemetry_pkg::SEND: begin
                if (frame_done) begin
                    fsm_next = telemetry_pkg::IDLE;
                end
            end
            default: begin
                fsm_next = telemetry_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fsm <= telemetry_pkg::IDLE;
            idx <= '0;
        end else begin
            fsm <= fsm_next;
            if (fsm == telemetry_pkg::LOAD) begin
                idx <= '0;
            end else if (wr_en) begin
                idx <= idx + 1'b1; // stalls while the FIFO is full.
            end
        end
    end

    // the line is built from this copy, so the live state may move on.
    always_ff @(posedge clk) begin
        if (frame_start) begin
            snap <= state;
        end
    end

    always_comb begin
        unique case (idx)
            6'd0:  wr_data = "C";
            6'd1:  wr_data = "X";
            6'd2:  wr_data = ":";
            6'd3:  wr_data = to_hex(snap.char_x[11:8]);
            6'd4:  wr_data = to_hex(snap.char_x[7:4]);
            6'd5:  wr_data = to_hex(snap.char_x[3:0]);
            6'd6:  wr_data = ",";
            6'd7:  wr_data = "Y";
            6'd8:  wr_data = ":";
            6'd9:  wr_data = to_hex(snap.char_y[11:8]);
            6'd10: wr_data = to_hex(snap.char_y[7:4]);
            6'd11: wr_data = to_hex(snap.char_y[3:0]);
            6'd12: wr_data = "|";
            6'd13: wr_data = "H";
            6'd14: wr_data = ":";
            6'd15: wr_data = to_hex(snap.char_hp);
            6'd16: wr_data = "|";
            6'd17: wr_data = "A";
            6'd18: wr_data = ":";
            6'd19: wr_data = to_hex(snap.char_aggro);
            6'd20: wr_data = "|";
            6'd21: wr_data = "B";
            6'd22: wr_data = "X";
            6'd23: wr_data = ":";
            6'd24: wr_data = to_hex(snap.boss_x[11:8]);
            6'd25: wr_data = to_hex(snap.boss_x[7:4]);
            6'd26: wr_data = to_hex(snap.boss_x[3:0]);
            6'd27: wr_data = ",";
            6'd28: wr_data = "Y";
            6'd29: wr_data = ":";
            6'd30: wr_data = to_hex(snap.boss_y[11:8]);
            6'd31: wr_data = to_hex(snap.boss_y[7:4]);
            6'd32: wr_data = to_hex(snap.boss_y[3:0]);
            6'd33: wr_data = "|";
            6'd34: wr_data = "B";
            6'd35: wr_data = "H";
            6'd36: wr_data = ":";
            6'd37: wr_data = to_hex({1'b0, snap.boss_hp[6:4]}); // top digit has three bits.
            6'd38: wr_data = to_hex(snap.boss_hp[3:0]);
            6'd39: wr_data = telemetry_pkg::ASCII_CR;
            6'd40: wr_data = telemetry_pkg::ASCII_LF;
            default: wr_data = telemetry_pkg::ASCII_LF;
        endcase
    end

endmodule

/* verilog/tx_fifo.sv */
`timescale 1ns/1ps

module tx_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  telemetry_pkg::uart_byte_t wr_data,
    input  logic                      rd_en,
    output telemetry_pkg::uart_byte_t rd_data,
    output logic                      full,
    output logic                      empty
);

    telemetry_pkg::uart_byte_t mem [telemetry_pkg::FIFO_DEPTH];

    logic [telemetry_pkg::FIFO_ADDR_W-1:0] wr_ptr;
    logic [telemetry_pkg::FIFO_ADDR_W-1:0] rd_ptr;
    logic [telemetry_pkg::FIFO_ADDR_W:0]   count;
    logic                                  do_wr;
    logic                                  do_rd;

    assign full  = (count == (telemetry_pkg::FIFO_ADDR_W + 1)'(telemetry_pkg::FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head is visible before the read, the pointer moves at the edge.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so it wraps.
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                      clk,
    input  logic                      rst,
    input  telemetry_pkg::uart_byte_t rd_data,
    input  logic                      empty,
    output logic                      rd_en,
    output logic                      txd
);

    logic                                 busy;
    logic [telemetry_pkg::BAUD_CNT_W-1:0] baud_cnt;
    logic [telemetry_pkg::BIT_CNT_W-1:0]  bit_cnt;
    logic [8:0]                           shreg;
    logic                                 tick;
    logic                                 last_bit;

    assign rd_en    = !busy && !empty;
    assign tick     = busy && (baud_cnt == telemetry_pkg::BAUD_CNT_W'(telemetry_pkg::CLKS_PER_BIT - 1));
    assign last_bit = (bit_cnt == telemetry_pkg::BIT_CNT_W'(telemetry_pkg::UART_BITS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1; // line idles high.
        end else if (rd_en) begin
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b0; // start bit.
        end else if (busy) begin
            if (tick) begin
                baud_cnt <= '0;
                if (last_bit) begin
                    busy <= 1'b0; // stop bit done, txd already high.
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    txd     <= shreg[0];
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // data goes out LSB first, with the stop bit parked on top.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            shreg <= {1'b1, rd_data};
        end else if (tick && !last_bit) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

/* verilog/game_telemetry.sv */
`timescale 1ns/1ps

module game_telemetry (
    input  logic                       clk,
    input  logic                       rst,
    input  telemetry_pkg::game_state_t state,
    output logic                       txd
);

    logic                      changed;
    logic                      credit;
    logic                      frame_start;
    logic                      frame_done;
    logic                      wr_en;
    telemetry_pkg::uart_byte_t wr_data;
    logic                      full;
    logic                      empty;
    logic                      rd_en;
    telemetry_pkg::uart_byte_t rd_data;

    state_change_detector i_state_change_detector (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .frame_start (frame_start),
        .changed     (changed)
    );

    frame_pacer i_frame_pacer (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .credit     (credit)
    );

    telemetry_encoder i_telemetry_encoder (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .changed     (changed),
        .credit      (credit),
        .full        (full),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    tx_fifo i_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (full),
        .empty   (empty)
    );

    uart_tx i_uart_tx (
        .clk     (clk),
        .rst     (rst),
        .rd_data (rd_data),
        .empty   (empty),
        .rd_en   (rd_en),
        .txd     (txd)
    );

endmodule

/* tests/game_telemetry_tb.sv */
`timescale 1ns/1ps

module game_telemetry_tb;

    localparam int NUM_ROWS  = 11;
    localparam int NUM_FIXED = 5;
    localparam int LONG_HOLD = 2 * telemetry_pkg::FRAME_INTERVAL;
    localparam int BIT_CLKS  = telemetry_pkg::CLKS_PER_BIT;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (2 * telemetry_pkg::FRAME_INTERVAL
        + telemetry_pkg::FRAME_LEN * 10 * telemetry_pkg::CLKS_PER_BIT);

    logic                       clk;
    logic                       rst;
    telemetry_pkg::game_state_t state;
    logic                       txd;

    telemetry_pkg::game_state_t row_state  [NUM_ROWS];
    int                         row_hold   [NUM_ROWS];
    bit                         row_expect [NUM_ROWS];

    telemetry_pkg::game_state_t exp_snaps [$]; // snapshots that must still show up as lines.
    telemetry_pkg::uart_byte_t  rx_bytes  [$]; // bytes of the line being received.
    telemetry_pkg::uart_byte_t  exp_line  [$];
    int                         lines_received = 0;
    int                         lines_expected = 0;

    game_telemetry i_game_telemetry (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .txd   (txd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("The watchdog expired before all rows were applied and checked.");
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "testbench error");
    endtask

    task automatic check_byte(input telemetry_pkg::uart_byte_t got,
                              input telemetry_pkg::uart_byte_t exp, input int position);
        if (got !== exp) begin
            report_mismatch($sformatf("line %0d byte %0d is 8'h%h, expected 8'h%h",
                                      lines_received, position, got, exp));
        end
    endtask

    task automatic check_frame_count(input int got, input int exp);
        if (got != exp) begin
            report_mismatch($sformatf("%0d lines received, expected %0d", got, exp));
        end
    endtask

    task automatic check_txd(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("txd is %b while the line should be %b", got, exp));
        end
    endtask

    function automatic telemetry_pkg::uart_byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + 8'(nib); // '0' to '9'.
        end else begin
            return 8'h41 + 8'(nib) - 8'd10; // 'A' to 'F'.
        end
    endfunction

    task automatic append_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            exp_line.push_back(text[i]);
        end
    endtask

    task automatic append_hex(input logic [11:0] value, input int digits);
        for (int i = digits - 1; i >= 0; i--) begin
            exp_line.push_back(hex_char(value[i*4 +: 4]));
        end
    endtask

    // expected line, most significant digit first.
    task automatic build_line(input telemetry_pkg::game_state_t s);
        exp_line.delete();
        append_text("CX:");
        append_hex(s.char_x, 3);
        append_text(",Y:");
        append_hex(s.char_y, 3);
        append_text("|H:");
        append_hex(12'(s.char_hp), 1);
        append_text("|A:");
        append_hex(12'(s.char_aggro), 1);
        append_text("|BX:");
        append_hex(s.boss_x, 3);
        append_text(",Y:");
        append_hex(s.boss_y, 3);
        append_text("|BH:");
        append_hex(12'(s.boss_hp), 2);
        exp_line.push_back(8'h0D);
        exp_line.push_back(8'h0A);
    endtask

    task automatic check_line();
        telemetry_pkg::game_state_t snap;
        if (exp_snaps.size() == 0) begin
            report_error($sformatf("A line arrived at %0d ns although no row asked for one.",
                                   $time));
        end else begin
            snap = exp_snaps.pop_front();
            build_line(snap);
            for (int i = 0; i < telemetry_pkg::FRAME_LEN; i++) begin
                check_byte(rx_bytes[i], exp_line[i], i);
            end
            rx_bytes.delete();
            lines_received++;
        end
    endtask

    // samples each bit in its middle, half a clock away from any txd edge.
    initial begin : uart_receiver
        telemetry_pkg::uart_byte_t data;
        @(negedge rst);
        forever begin
            @(negedge txd);
            repeat (BIT_CLKS / 2) @(negedge clk);
            if (txd !== 1'b0) begin
                report_error("A start bit on txd ended before its middle.");
            end
            for (int b = 0; b < 8; b++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[b] = txd;
            end
            repeat (BIT_CLKS) @(negedge clk);
            if (txd !== 1'b1) begin
                report_error($sformatf("The stop bit of a byte was low at %0d ns.", $time));
            end
            rx_bytes.push_back(data);
            if (rx_bytes.size() == telemetry_pkg::FRAME_LEN) begin
                check_line();
            end
        end
    end

    // rows 2 to 4 change the snapshot while a line is sent and before credit returns.
    task automatic fill_table();
        logic [63:0] raw;
        row_state[0] = '{char_x: 12'h123, char_y: 12'h456, char_hp: 4'h7, char_aggro: 4'h2,
                         boss_x: 12'h089, boss_y: 12'h310, boss_hp: 7'h25};
        row_state[1] = row_state[0];
        row_state[2] = '{char_x: 12'hABC, char_y: 12'hDEF, char_hp: 4'hA, char_aggro: 4'hF,
                         boss_x: 12'hF0E, boss_y: 12'hC1D, boss_hp: 7'h7F};
        row_state[3] = '{char_x: 12'h111, char_y: 12'h222, char_hp: 4'h3, char_aggro: 4'h4,
                         boss_x: 12'h555, boss_y: 12'h666, boss_hp: 7'h17};
        row_state[4] = '{char_x: 12'hFED, char_y: 12'hCBA, char_hp: 4'hB, char_aggro: 4'hC,
                         boss_x: 12'hE9A, boss_y: 12'h5B4, boss_hp: 7'h5A};
        row_hold[0] = LONG_HOLD;
        row_hold[1] = 3 * telemetry_pkg::FRAME_INTERVAL;
        row_hold[2] = 200;
        row_hold[3] = 2800; // row 4 lands after the encoder is done but before the next credit.
        row_hold[4] = LONG_HOLD;
        row_expect[0] = 1'b1;
        row_expect[1] = 1'b0;
        row_expect[2] = 1'b1;
        row_expect[3] = 1'b0;
        row_expect[4] = 1'b1;
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            raw = {$urandom(), $urandom()};
            row_state[i] = raw[62:0];
            if (row_state[i] == row_state[i-1]) begin
                row_state[i].char_x = row_state[i].char_x ^ 12'h001;
            end
            row_hold[i]   = LONG_HOLD;
            row_expect[i] = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'hcb985dcc));
        rst   = 1'b1;
        state = '0;
        fill_table();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        check_txd(txd, 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #1 state = row_state[i];
            if (row_expect[i]) begin
                exp_snaps.push_back(row_state[i]);
                lines_expected++;
            end
            repeat (row_hold[i] - 1) @(posedge clk);
            #1;
            // a long row leaves time for every pending line to finish.
            if (row_hold[i] >= LONG_HOLD) begin
                check_frame_count(lines_received, lines_expected);
                check_txd(txd, 1'b1);
                if (rx_bytes.size() != 0) begin
                    report_mismatch($sformatf("%0d stray bytes after row %0d",
                                              rx_bytes.size(), i));
                end
            end
        end
        check_frame_count(lines_received, lines_expected);
        $display("Test passed");
        $finish;
    end

endmodule

/* game_telemetry.f */
verilog/telemetry_pkg.sv
verilog/state_change_detector.sv
verilog/frame_pacer.sv
verilog/telemetry_encoder.sv
verilog/tx_fifo.sv
verilog/uart_tx.sv
verilog/game_telemetry.sv
tests/game_telemetry_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the telemetry testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module game_telemetry_tb \
    -f game_telemetry.f -o sim_game_telemetry > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed."; exit 1; }

./obj_dir/sim_game_telemetry > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation reported a failure."; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation ended without a pass line."; exit 1; }

echo "Simulation finished cleanly."
exit 0
